// ==== logic/pattern_sort_pkg.sv ====
`default_nettype none

package pattern_sort_pkg;

  // ----------------------------------------------------------------------
  // field widths
  // ----------------------------------------------------------------------
  localparam int NUM_CFEB = 7;
  // pattern number, lsb carries the bend direction
  localparam int PAT_W    = 7;
  localparam int KEY_W    = 5;
  localparam int OFFS_W   = 4;
  localparam int QLT_W    = 6;
  localparam int BEND_W   = 4;
  localparam int CARRY_W  = 12;
  localparam int CFEB_W   = 3;
  // chamber-wide key is cfeb index over the local half-strip
  localparam int KEYX_W   = CFEB_W + KEY_W;
  // two extra bits for quarter and eighth strip
  localparam int SUBKEY_W = KEYX_W + 2;
  localparam int SORT_W   = 6;

  typedef logic [CFEB_W-1:0]   cfeb_idx_t;
  typedef logic [KEYX_W-1:0]   keyx_t;
  typedef logic [SUBKEY_W-1:0] subkey_t;
  typedef logic [SORT_W-1:0]   sort_key_t;

  // ----------------------------------------------------------------------
  // payload structs
  // ----------------------------------------------------------------------
  // one pattern candidate from a single cfeb, 38 bits
  typedef struct packed {
    logic [PAT_W-1:0]   pat;
    logic [KEY_W-1:0]   key;
    logic [OFFS_W-1:0]  offs;
    logic [QLT_W-1:0]   qlt;
    logic [BEND_W-1:0]  bend;
    logic [CARRY_W-1:0] carry;
  } pattern_cand_t;

  // input frame, element n belongs to cfeb n
  typedef pattern_cand_t [NUM_CFEB-1:0] cand_frame_t;

  // winner of one group sorter, cfeb index kept for the key math
  typedef struct packed {
    cfeb_idx_t     cfeb;
    pattern_cand_t cand;
  } group_best_t;

  // final chamber result
  typedef struct packed {
    logic [PAT_W-1:0]   pat;
    keyx_t              key;
    subkey_t            subkey;
    logic [BEND_W-1:0]  bend;
    logic [CARRY_W-1:0] carry;
    logic [QLT_W-1:0]   qlt;
  } best_lct_t;

  // sort on fit quality, or on pattern number with the bend lsb dropped
  function automatic sort_key_t sort_key_of(input pattern_cand_t cand, input bit on_qlt);
    sort_key_t key;
    if (on_qlt)
      key = cand.qlt;
    else
      key = cand.pat[PAT_W-1:1];
    return key;
  endfunction

endpackage

`default_nettype wire

// ==== logic/cfeb_group_sort.sv ====
`timescale 1ns/10ps
`default_nettype none

module cfeb_group_sort #(
  parameter int N_CAND      = 4,
  parameter int CFEB_BASE   = 0,
  parameter bit SORT_ON_QLT = 1'b0
) (
  input  logic                                       clock,
  input  logic                                       reset,
  input  logic                                       cand_valid,
  output logic                                       cand_ready,
  input  pattern_sort_pkg::pattern_cand_t [N_CAND-1:0] cands,
  output logic                                       best_valid,
  input  logic                                       best_ready,
  output pattern_sort_pkg::group_best_t              best
);

  // sort key per candidate
  pattern_sort_pkg::sort_key_t cand_key [N_CAND];

  // running winner of the scan
  pattern_sort_pkg::sort_key_t     win_key;
  pattern_sort_pkg::pattern_cand_t win_cand;
  pattern_sort_pkg::cfeb_idx_t     win_cfeb;

  pattern_sort_pkg::group_best_t best_d;
  logic                          load;

  // ----------------------------------------------------------------------
  // sort keys
  // ----------------------------------------------------------------------
  genvar g;
  generate
    for (g = 0; g < N_CAND; g++)
    begin : g_key
      // same key rule as the merge stage and the model
      assign cand_key[g] = pattern_sort_pkg::sort_key_of(cands[g], SORT_ON_QLT);
    end
  endgenerate

  // ----------------------------------------------------------------------
  // best-of-n scan
  // ----------------------------------------------------------------------
  // a higher slot only takes over on a strictly larger key,
  // so equal keys leave the lowest cfeb in place
  always_comb
  begin
    win_key  = cand_key[0];
    win_cand = cands[0];
    win_cfeb = pattern_sort_pkg::cfeb_idx_t'(CFEB_BASE);
    for (int i = 1; i < N_CAND; i++)
    begin
      if (cand_key[i] > win_key)
      begin
        win_key  = cand_key[i];
        win_cand = cands[i];
        // chamber cfeb number, not the slot within the group
        win_cfeb = pattern_sort_pkg::cfeb_idx_t'(CFEB_BASE + i);
      end
    end
  end

  assign best_d.cfeb = win_cfeb;
  assign best_d.cand = win_cand;

  // ----------------------------------------------------------------------
  // output stage, valid/ready
  // ----------------------------------------------------------------------
  // open when empty or when the merge takes the held winner this cycle
  assign cand_ready = !best_valid || best_ready;
  assign load       = cand_valid && cand_ready;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      best_valid <= 1'b0;
    end
    else if (cand_ready)
    begin
      // refill or drain on the same edge
      best_valid <= cand_valid;
    end
  end

  // winner payload, only written on a real transfer
  always_ff @(posedge clock)
  begin
    if (load)
    begin
      best <= best_d;
    end
  end

endmodule

`default_nettype wire

// ==== logic/best_cfeb_merge.sv ====
`timescale 1ns/10ps
`default_nettype none

module best_cfeb_merge #(
  parameter bit SORT_ON_QLT = 1'b0
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          lo_valid,
  input  logic                          hi_valid,
  output logic                          grp_ready,
  input  pattern_sort_pkg::group_best_t lo_best,
  input  pattern_sort_pkg::group_best_t hi_best,
  output logic                          out_valid,
  input  logic                          out_ready,
  output pattern_sort_pkg::best_lct_t   out_result
);

  pattern_sort_pkg::sort_key_t   lo_key;
  pattern_sort_pkg::sort_key_t   hi_key;
  logic                          hi_wins;
  pattern_sort_pkg::group_best_t win;

  // key arithmetic terms
  pattern_sort_pkg::keyx_t   key_base;
  pattern_sort_pkg::keyx_t   key_coarse;
  pattern_sort_pkg::keyx_t   key_round;
  pattern_sort_pkg::keyx_t   key_x;
  logic [1:0]                sub_lsb;
  pattern_sort_pkg::subkey_t subkey;

  pattern_sort_pkg::best_lct_t result_d;
  logic                        both_valid;
  logic                        consume;

  // ----------------------------------------------------------------------
  // pick between the two groups
  // ----------------------------------------------------------------------
  assign lo_key = pattern_sort_pkg::sort_key_of(lo_best.cand, SORT_ON_QLT);
  assign hi_key = pattern_sort_pkg::sort_key_of(hi_best.cand, SORT_ON_QLT);

  // strict compare, low group holds on a tie like the flat 1-of-7 would
  assign hi_wins = hi_key > lo_key;
  assign win     = hi_wins ? hi_best : lo_best;

  // ----------------------------------------------------------------------
  // chamber key and subkey
  // ----------------------------------------------------------------------
  // cfeb index on top of the local half-strip
  assign key_base   = {win.cfeb, win.cand.key};

  // offset bits 3..2 give the half-strip shift
  assign key_coarse = pattern_sort_pkg::keyx_t'(win.cand.offs[3:2]);

  // extra step when both low offset bits are set
  assign key_round  = pattern_sort_pkg::keyx_t'(win.cand.offs[1] & win.cand.offs[0]);

  // centre the shift with -2, wraps modulo 2^KEYX_W
  assign key_x = key_base + key_coarse + key_round - pattern_sort_pkg::keyx_t'(2);

  // quarter/eighth bits, offset lsbs plus one modulo 4
  assign sub_lsb = win.cand.offs[1:0] + 2'd1;
  assign subkey  = {key_x, sub_lsb};

  // result fields straight from the winning candidate
  assign result_d.pat    = win.cand.pat;
  assign result_d.key    = key_x;
  assign result_d.subkey = subkey;
  assign result_d.bend   = win.cand.bend;
  assign result_d.carry  = win.cand.carry;
  assign result_d.qlt    = win.cand.qlt;

  // ----------------------------------------------------------------------
  // output stage, valid/ready
  // ----------------------------------------------------------------------
  // one ready to both groups, they always move together
  assign grp_ready  = !out_valid || out_ready;
  assign both_valid = lo_valid && hi_valid;
  assign consume    = both_valid && grp_ready;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      out_valid <= 1'b0;
    end
    else if (grp_ready)
    begin
      // only a pair of group winners makes a result
      out_valid <= both_valid;
    end
  end

  // held while out_ready is low
  always_ff @(posedge clock)
  begin
    if (consume)
    begin
      out_result <= result_d;
    end
  end

endmodule

`default_nettype wire

// ==== logic/pattern_sorter_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module pattern_sorter_top #(
  parameter bit SORT_ON_QLT = 1'b0
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  pattern_sort_pkg::cand_frame_t in_frame,
  output logic                          out_valid,
  input  logic                          out_ready,
  output pattern_sort_pkg::best_lct_t   out_result
);

  // low group handshake
  logic                          lo_ready;
  logic                          lo_valid;
  pattern_sort_pkg::group_best_t lo_best;

  // high group handshake
  logic                          hi_valid;
  pattern_sort_pkg::group_best_t hi_best;

  // merge ready, shared by both groups
  logic grp_ready;

  // ----------------------------------------------------------------------
  // group sorters
  // ----------------------------------------------------------------------
  // both see the same valid and the same merge ready, so their
  // registers stay in step and the low ready speaks for both
  assign in_ready = lo_ready;

  // cfeb 0..3
  cfeb_group_sort #(
    .N_CAND      (4),
    .CFEB_BASE   (0),
    .SORT_ON_QLT (SORT_ON_QLT)
  ) lo_sort_i (
    .clock      (clock),
    .reset      (reset),
    .cand_valid (in_valid),
    .cand_ready (lo_ready),
    .cands      (in_frame[3:0]),
    .best_valid (lo_valid),
    .best_ready (grp_ready),
    .best       (lo_best)
  );

  // cfeb 4..6, ready matches the low group every cycle
  cfeb_group_sort #(
    .N_CAND      (3),
    .CFEB_BASE   (4),
    .SORT_ON_QLT (SORT_ON_QLT)
  ) hi_sort_i (
    .clock      (clock),
    .reset      (reset),
    .cand_valid (in_valid),
    .cand_ready (),
    .cands      (in_frame[6:4]),
    .best_valid (hi_valid),
    .best_ready (grp_ready),
    .best       (hi_best)
  );

  // ----------------------------------------------------------------------
  // merge and key calculation
  // ----------------------------------------------------------------------
  best_cfeb_merge #(
    .SORT_ON_QLT (SORT_ON_QLT)
  ) merge_i (
    .clock      (clock),
    .reset      (reset),
    .lo_valid   (lo_valid),
    .hi_valid   (hi_valid),
    .grp_ready  (grp_ready),
    .lo_best    (lo_best),
    .hi_best    (hi_best),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
  );

endmodule

`default_nettype wire

// ==== tests/pattern_sorter_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module pattern_sorter_checker (
  input logic                        clock,
  input logic                        reset,
  input logic                        in_ready,
  input logic                        out_valid,
  input logic                        out_ready,
  input pattern_sort_pkg::best_lct_t out_result,
  input logic                        lo_valid,
  input logic                        hi_valid
);

  // count of failed assertions
  int unsigned fail_count = 0;

  // pipeline empty and input open after reset
  reset_empty_a: assert property (@(posedge clock)
    reset |=> !out_valid && !lo_valid && !hi_valid && in_ready)
  else
  begin
    $error("pipeline not empty after reset");
    fail_count = fail_count + 1;
  end

  // output held while the consumer stalls
  out_hold_a: assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_result))
  else
  begin
    $error("out_valid or out_result changed while out_ready was low");
    fail_count = fail_count + 1;
  end

  // both group registers move in step
  groups_in_step_a: assert property (@(posedge clock) disable iff (reset)
    lo_valid == hi_valid)
  else
  begin
    $error("group sorter valids differ");
    fail_count = fail_count + 1;
  end

  // input reopens once the output drains
  ready_return_a: assert property (@(posedge clock) disable iff (reset)
    out_ready && !(lo_valid && out_valid) |-> ##[0:1] in_ready)
  else
  begin
    $error("in_ready stayed low with out_ready high and room in the pipeline");
    fail_count = fail_count + 1;
  end

endmodule

`default_nettype wire

// ==== tests/pattern_sorter_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module pattern_sorter_tb;

  localparam int TIMEOUT = 64;

  logic                          clock;
  logic                          reset;
  logic                          in_valid;
  pattern_sort_pkg::cand_frame_t in_frame;
  logic                          out_ready;

  // stimulus and out_ready step their own lfsr state
  logic [15:0] stim_lfsr  = 16'd4;
  logic [15:0] ready_lfsr = 16'd4;
  logic        rand_ready;
  logic        use_rand;
  int          cycle    = 0;
  int          last_low = -1;
  int          sent     = 0;

  bind pattern_sorter_top pattern_sorter_checker checker_i (
    .clock      (clock),
    .reset      (reset),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result),
    .lo_valid   (lo_valid),
    .hi_valid   (hi_valid)
  );

  // ----------------------------------------------------------------------
  // random source
  // ----------------------------------------------------------------------
  // galois form with feedback mask b400
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], stim_lfsr[0]};
      stim_lfsr = lfsr_next(stim_lfsr);
    end
    return v;
  endfunction

  // random frame
  // equal copies the sort fields of cfeb 0 to every cfeb
  // top6 then makes cfeb 6 strictly best in both sort modes
  function automatic pattern_sort_pkg::cand_frame_t make_frame(input bit equal, input bit top6);
    pattern_sort_pkg::cand_frame_t f;
    for (int c = 0; c < 7; c++)
    begin
      f[c].pat   = 7'(rand_bits(7));
      f[c].key   = 5'(rand_bits(5));
      f[c].offs  = 4'(rand_bits(4));
      f[c].qlt   = 6'(rand_bits(6));
      f[c].bend  = 4'(rand_bits(4));
      f[c].carry = 12'(rand_bits(12));
      if (equal)
      begin
        f[c].pat[6:1] = f[0].pat[6:1];
        f[c].qlt      = f[0].qlt;
      end
      f[c].pat[6] = top6 ? (c == 6) : f[c].pat[6];
      f[c].qlt[5] = top6 ? (c == 6) : f[c].qlt[5];
    end
    return f;
  endfunction

  // ----------------------------------------------------------------------
  // reference model as a flat best-of-7
  // ----------------------------------------------------------------------
  function automatic pattern_sort_pkg::best_lct_t model_result(
    input pattern_sort_pkg::cand_frame_t f, input bit on_qlt);
    pattern_sort_pkg::best_lct_t r;
    int best;
    int best_k;
    int k;
    int keyx;
    best   = 0;
    best_k = -1;
    for (int c = 0; c < 7; c++)
    begin
      // quality or pattern without the bend bit
      k = on_qlt ? int'(f[c].qlt) : int'(f[c].pat) / 2;
      if (k > best_k)
      begin
        best   = c;
        best_k = k;
      end
    end
    keyx = best * 32 + int'(f[best].key) + int'(f[best].offs) / 4 - 2;
    if (f[best].offs[1:0] == 2'b11)
      keyx = keyx + 1;
    r.pat    = f[best].pat;
    r.key    = 8'(keyx & 255);
    r.subkey = {r.key, 2'(int'(f[best].offs[1:0]) + 1)};
    r.bend   = f[best].bend;
    r.carry  = f[best].carry;
    r.qlt    = f[best].qlt;
    return r;
  endfunction

  task automatic stop_with_failure();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_field(input string name, input int mode,
                               input logic [15:0] got, input logic [15:0] exp);
    assert (got == exp)
    else
    begin
      $display("FAIL %s (mode %0d) got 0x%0h expected 0x%0h", name, mode, got, exp);
      stop_with_failure();
    end
  endtask

  // hold valid and frame until copy 0 takes it
  // both copies move together
  task automatic send_frame(input pattern_sort_pkg::cand_frame_t f);
    int   waited;
    logic taken;
    waited   = 0;
    taken    = 1'b0;
    in_frame = f;
    in_valid = 1'b1;
    while (!taken)
    begin
      @(posedge clock);
      taken = g_mode[0].in_ready;
      waited++;
      if (!taken && waited >= TIMEOUT)
      begin
        $display("timeout: frame %0d was not accepted within %0d cycles", sent, TIMEOUT);
        stop_with_failure();
      end
    end
    sent++;
    #1;
    in_valid = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // clock, out_ready, cycle count
  // ----------------------------------------------------------------------
  initial
  begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial
  begin
    out_ready = 1'b1;
    forever
    begin
      @(posedge clock);
      use_rand = rand_ready;
      #1;
      if (use_rand)
      begin
        out_ready  = ready_lfsr[0];
        ready_lfsr = lfsr_next(ready_lfsr);
      end
      else
        out_ready = 1'b1;
    end
  end

  // last edge with out_ready low
  always @(posedge clock)
  begin
    cycle <= cycle + 1;
    if (!out_ready)
      last_low <= cycle;
  end

  // ----------------------------------------------------------------------
  // one DUT per sort mode with its own expected queue
  // ----------------------------------------------------------------------
  genvar m;
  generate
    for (m = 0; m < 2; m++)
    begin : g_mode
      logic                        in_ready;
      logic                        out_valid;
      pattern_sort_pkg::best_lct_t out_result;
      pattern_sort_pkg::best_lct_t exp_q [$];
      int                          acc_q [$];
      pattern_sort_pkg::best_lct_t exp_r;
      int                          acc_c;
      int                          checked = 0;

      pattern_sorter_top #(
        .SORT_ON_QLT (m == 1)
      ) dut_i (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_frame   (in_frame),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
      );

      always @(posedge clock)
      begin
        if (dut_i.checker_i.fail_count != 0)
        begin
          $display("mode %0d: a protocol assertion in the checker failed", m);
          stop_with_failure();
        end
        if (!reset && out_valid && out_ready)
        begin
          if (exp_q.size() == 0)
          begin
            $display("mode %0d: output transfer with no frame pending", m);
            stop_with_failure();
          end
          else
          begin
            exp_r = exp_q.pop_front();
            acc_c = acc_q.pop_front();
            compare_field("out_result.pat", m, 16'(out_result.pat), 16'(exp_r.pat));
            compare_field("out_result.key", m, 16'(out_result.key), 16'(exp_r.key));
            compare_field("out_result.subkey", m, 16'(out_result.subkey), 16'(exp_r.subkey));
            compare_field("out_result.bend", m, 16'(out_result.bend), 16'(exp_r.bend));
            compare_field("out_result.carry", m, 16'(out_result.carry), 16'(exp_r.carry));
            compare_field("out_result.qlt", m, 16'(out_result.qlt), 16'(exp_r.qlt));
            // no stall since acceptance means exactly two edges
            if (last_low <= acc_c)
              compare_field("out_valid latency", m, 16'(cycle - acc_c), 16'd2);
            checked++;
          end
        end
        if (!reset && in_valid && in_ready)
        begin
          exp_q.push_back(model_result(in_frame, m == 1));
          acc_q.push_back(cycle);
        end
      end
    end
  endgenerate

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial
  begin
    pattern_sort_pkg::cand_frame_t f;
    int waited;
    in_valid   = 1'b0;
    in_frame   = '0;
    rand_ready = 1'b0;
    reset      = 1'b1;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    // all keys tied and then a strict winner on cfeb 6
    send_frame(make_frame(1'b1, 1'b0));
    send_frame(make_frame(1'b1, 1'b1));
    // key wraps below zero on cfeb 0
    f = make_frame(1'b1, 1'b0);
    f[0].key  = '0;
    f[0].offs = '0;
    send_frame(f);
    // offsets with both low bits set
    for (int i = 0; i < 4; i++)
    begin
      f = make_frame(1'b1, 1'b1);
      f[6].offs = 4'(4 * i + 3);
      send_frame(f);
      f = make_frame(1'b1, 1'b0);
      f[0].key  = '0;
      f[0].offs = 4'(4 * i + 3);
      send_frame(f);
    end
    // back to back with out_ready high
    repeat (40) send_frame(make_frame(1'b0, 1'b0));
    // random gaps and random back-pressure
    rand_ready = 1'b1;
    repeat (150)
    begin
      if (rand_bits(1) != 0)
      begin
        @(posedge clock);
        #1;
      end
      send_frame(make_frame(1'b0, 1'b0));
    end
    rand_ready = 1'b0;
    waited = 0;
    while (g_mode[0].checked < sent || g_mode[1].checked < sent)
    begin
      @(posedge clock);
      #1;
      waited++;
      if (waited >= TIMEOUT)
      begin
        $display("timeout: results still pending after the last frame");
        stop_with_failure();
      end
    end
    // a few more edges to catch any extra output
    repeat (4) @(posedge clock);
    if (g_mode[0].checked == sent && g_mode[1].checked == sent &&
        g_mode[0].exp_q.size() == 0 && g_mode[1].exp_q.size() == 0)
    begin
      $display("TEST PASSED");
      $finish;
    end
    else
    begin
      $display("%0d frames sent, but results are missing or still queued", sent);
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/pattern_sort_pkg.sv
logic/cfeb_group_sort.sv
logic/best_cfeb_merge.sv
logic/pattern_sorter_top.sv
tests/pattern_sorter_checker.sv
tests/pattern_sorter_tb.sv

// ==== Makefile ====
# Verilator build and run of the pattern sorter testbench

VERILATOR  ?= verilator
TOP        ?= pattern_sorter_tb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
SIM_ARGS   ?= +verilator+error+limit+100
FAIL_MSG   ?= TEST FAILED
PASS_MSG   ?= TEST PASSED

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# verdict comes from the log, not from the exit status
run: build
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no pass message in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
